/* design/exec_units.sv */
`timescale 1ns/10ps

module exec_units (
    input  logic              clock,
    input  logic              reset,
    input  logic              alu_issue,
    input  ooo_pkg::op_t      alu_op,
    input  ooo_pkg::word_t    alu_a,
    input  ooo_pkg::word_t    alu_b,
    input  ooo_pkg::rob_tag_t alu_tag,
    input  logic              mul_issue,
    input  ooo_pkg::word_t    mul_a,
    input  ooo_pkg::word_t    mul_b,
    input  ooo_pkg::rob_tag_t mul_tag,
    output logic              alu_ready,
    output logic              cdb_valid,
    output ooo_pkg::rob_tag_t cdb_tag,
    output ooo_pkg::word_t    cdb_value
);

    ooo_pkg::word_t    alu_result;
    logic              alu_valid_q;
    ooo_pkg::rob_tag_t alu_tag_q;
    ooo_pkg::word_t    alu_value_q;

    // Multiplier stages 1..3 held at index 0..2
    logic              mul_valid_q [3];
    ooo_pkg::rob_tag_t mul_tag_q   [3];
    ooo_pkg::word_t    mul_value_q [3];

    always_comb begin
        case (alu_op)
            ooo_pkg::op_sub: alu_result = alu_a - alu_b;
            ooo_pkg::op_and: alu_result = alu_a & alu_b;
            ooo_pkg::op_or:  alu_result = alu_a | alu_b;
            ooo_pkg::op_xor: alu_result = alu_a ^ alu_b;
            ooo_pkg::op_li:  alu_result = alu_a;      // Immediate sits in operand A
            default:         alu_result = alu_a + alu_b;
        endcase
    end

    // Stage 2 moves onto the CDB next cycle, so the ALU holds off
    assign alu_ready = !mul_valid_q[1];

    assign cdb_valid = mul_valid_q[2] || alu_valid_q;
    assign cdb_tag   = mul_valid_q[2] ? mul_tag_q[2] : alu_tag_q;
    assign cdb_value = mul_valid_q[2] ? mul_value_q[2] : alu_value_q;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_valid_q    <= 1'b0;
            mul_valid_q[0] <= 1'b0;
            mul_valid_q[1] <= 1'b0;
            mul_valid_q[2] <= 1'b0;
        end else begin
            alu_valid_q    <= alu_issue;
            mul_valid_q[0] <= mul_issue;
            mul_valid_q[1] <= mul_valid_q[0];
            mul_valid_q[2] <= mul_valid_q[1];
        end
    end

    always_ff @(posedge clock) begin
        alu_tag_q      <= alu_tag;
        alu_value_q    <= alu_result;
        mul_tag_q[0]   <= mul_tag;
        mul_value_q[0] <= mul_a * mul_b;    // Low word of the product
        mul_tag_q[1]   <= mul_tag_q[0];
        mul_value_q[1] <= mul_value_q[0];
        mul_tag_q[2]   <= mul_tag_q[1];
        mul_value_q[2] <= mul_value_q[1];
    end

endmodule

/* design/ooo_core.sv */
`timescale 1ns/10ps

module ooo_core (
    input  logic                clock,
    input  logic                reset,
    input  logic                dispatch_valid,
    input  ooo_pkg::op_t        dispatch_op,
    input  ooo_pkg::reg_index_t dispatch_rd,
    input  ooo_pkg::reg_index_t dispatch_rs1,
    input  ooo_pkg::reg_index_t dispatch_rs2,
    input  ooo_pkg::word_t      dispatch_imm,
    output logic                dispatch_stall,
    output logic                commit_valid,
    output ooo_pkg::reg_index_t commit_rd,
    output ooo_pkg::rob_tag_t   commit_tag,
    output ooo_pkg::word_t      commit_value
);

    logic              dispatch_accept;
    ooo_pkg::rob_tag_t alloc_tag;
    logic              rob_full;

    // Operand read at dispatch
    ooo_pkg::word_t    rs1_value, rs2_value;
    logic              rs1_busy, rs2_busy;
    ooo_pkg::rob_tag_t rs1_tag, rs2_tag;
    logic              lookup1_done, lookup2_done;
    ooo_pkg::word_t    lookup1_value, lookup2_value;

    // Issue and result broadcast
    logic              alu_ready, alu_issue, mul_issue;
    ooo_pkg::op_t      alu_op;
    ooo_pkg::word_t    alu_a, alu_b, mul_a, mul_b;
    ooo_pkg::rob_tag_t alu_tag, mul_tag;
    logic              cdb_valid;
    ooo_pkg::rob_tag_t cdb_tag;
    ooo_pkg::word_t    cdb_value;

    rename_register_file u_rename (
        .rs1 (dispatch_rs1),
        .rs2 (dispatch_rs2),
        .*
    );

    reorder_buffer u_rob (
        .lookup1_tag (rs1_tag),
        .lookup2_tag (rs2_tag),
        .*
    );

    reservation_station u_rs (.*);

    exec_units u_exec (.*);

endmodule

/* design/ooo_pkg.sv */
`include "ooo_config.svh"

package ooo_pkg;

    typedef logic [`OOO_XLEN-1:0] word_t;

    typedef logic [$clog2(`OOO_NUM_REGS)-1:0] reg_index_t;   // 5 bits

    // ROB slot index that doubles as the tag of the result
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_tag_t;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_li,      // Load immediate into rd
        op_mul
    } op_t;

    typedef enum logic {
        fu_alu,
        fu_mul
    } fu_class_t;

    // Per-entry reservation station state
    typedef enum logic [1:0] {
        slot_free,
        slot_waiting,
        slot_ready
    } rs_state_t;

endpackage

/* design/rename_register_file.sv */
`timescale 1ns/10ps
`include "ooo_config.svh"

module rename_register_file (
    input  logic                clock,
    input  logic                reset,
    input  ooo_pkg::reg_index_t rs1,
    input  ooo_pkg::reg_index_t rs2,
    input  logic                dispatch_accept,
    input  ooo_pkg::reg_index_t dispatch_rd,
    input  ooo_pkg::rob_tag_t   alloc_tag,
    input  logic                commit_valid,
    input  ooo_pkg::reg_index_t commit_rd,
    input  ooo_pkg::rob_tag_t   commit_tag,
    input  ooo_pkg::word_t      commit_value,
    output ooo_pkg::word_t      rs1_value,
    output ooo_pkg::word_t      rs2_value,
    output logic                rs1_busy,
    output logic                rs2_busy,
    output ooo_pkg::rob_tag_t   rs1_tag,
    output ooo_pkg::rob_tag_t   rs2_tag
);

    ooo_pkg::word_t    value [`OOO_NUM_REGS];
    logic              busy  [`OOO_NUM_REGS];
    ooo_pkg::rob_tag_t tag   [`OOO_NUM_REGS];   // Pending writer

    // Entry 0 is never written or renamed, so it reads zero and not busy
    assign rs1_value = value[rs1];
    assign rs2_value = value[rs2];
    assign rs1_busy  = busy[rs1];
    assign rs2_busy  = busy[rs2];
    assign rs1_tag   = tag[rs1];
    assign rs2_tag   = tag[rs2];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                value[i] <= '0;
                busy[i]  <= 1'b0;
                tag[i]   <= '0;
            end
        end else begin
            // Commits arrive in program order, so the value is always architectural
            if (commit_valid && commit_rd != '0) begin
                value[commit_rd] <= commit_value;
                if (busy[commit_rd] && tag[commit_rd] == commit_tag) begin
                    busy[commit_rd] <= 1'b0;    // Only the latest writer clears
                end
            end
            // New rename overrides a same-cycle clear
            if (dispatch_accept && dispatch_rd != '0) begin
                busy[dispatch_rd] <= 1'b1;
                tag[dispatch_rd]  <= alloc_tag;
            end
        end
    end

endmodule

/* design/reorder_buffer.sv */
`timescale 1ns/10ps
`include "ooo_config.svh"

module reorder_buffer (
    input  logic                clock,
    input  logic                reset,
    input  logic                dispatch_accept,
    input  ooo_pkg::reg_index_t dispatch_rd,
    input  logic                cdb_valid,
    input  ooo_pkg::rob_tag_t   cdb_tag,
    input  ooo_pkg::word_t      cdb_value,
    input  ooo_pkg::rob_tag_t   lookup1_tag,
    input  ooo_pkg::rob_tag_t   lookup2_tag,
    output ooo_pkg::rob_tag_t   alloc_tag,
    output logic                rob_full,
    output logic                lookup1_done,
    output ooo_pkg::word_t      lookup1_value,
    output logic                lookup2_done,
    output ooo_pkg::word_t      lookup2_value,
    output logic                commit_valid,
    output ooo_pkg::reg_index_t commit_rd,
    output ooo_pkg::rob_tag_t   commit_tag,
    output ooo_pkg::word_t      commit_value
);

    localparam int count_bits = $clog2(`OOO_ROB_DEPTH) + 1;

    ooo_pkg::reg_index_t entry_rd    [`OOO_ROB_DEPTH];
    ooo_pkg::word_t      entry_value [`OOO_ROB_DEPTH];
    logic                entry_done  [`OOO_ROB_DEPTH];

    ooo_pkg::rob_tag_t     head;
    ooo_pkg::rob_tag_t     tail;
    logic [count_bits-1:0] count;
    logic                  retire;

    assign alloc_tag = tail;
    assign rob_full  = (count == count_bits'(`OOO_ROB_DEPTH));
    assign retire    = (count != '0) && entry_done[head];

    // Done bits stay set after retirement until the slot is reused, which
    // covers the cycle where the rename file still shows the retired tag
    assign lookup1_done  = entry_done[lookup1_tag];
    assign lookup1_value = entry_value[lookup1_tag];
    assign lookup2_done  = entry_done[lookup2_tag];
    assign lookup2_value = entry_value[lookup2_tag];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
            for (int i = 0; i < `OOO_ROB_DEPTH; i++) begin
                entry_done[i] <= 1'b0;
            end
        end else begin
            if (dispatch_accept) begin
                entry_done[tail] <= 1'b0;
                tail             <= tail + 1'b1;
            end
            if (cdb_valid) begin
                entry_done[cdb_tag] <= 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count        <= count + count_bits'(dispatch_accept) - count_bits'(retire);
            commit_valid <= retire;
        end
    end

    // Entry payload and the commit word
    always_ff @(posedge clock) begin
        if (dispatch_accept) begin
            entry_rd[tail] <= dispatch_rd;
        end
        if (cdb_valid) begin
            entry_value[cdb_tag] <= cdb_value;
        end
        commit_rd    <= entry_rd[head];
        commit_tag   <= head;
        commit_value <= entry_value[head];
    end

endmodule

/* design/reservation_station.sv */
`timescale 1ns/10ps
`include "ooo_config.svh"

module reservation_station (
    input  logic              clock,
    input  logic              reset,
    input  logic              dispatch_valid,
    input  ooo_pkg::op_t      dispatch_op,
    input  ooo_pkg::word_t    dispatch_imm,
    input  logic              rob_full,
    input  ooo_pkg::rob_tag_t alloc_tag,
    input  ooo_pkg::word_t    rs1_value,
    input  logic              rs1_busy,
    input  ooo_pkg::rob_tag_t rs1_tag,
    input  ooo_pkg::word_t    rs2_value,
    input  logic              rs2_busy,
    input  ooo_pkg::rob_tag_t rs2_tag,
    input  logic              lookup1_done,
    input  ooo_pkg::word_t    lookup1_value,
    input  logic              lookup2_done,
    input  ooo_pkg::word_t    lookup2_value,
    input  logic              cdb_valid,
    input  ooo_pkg::rob_tag_t cdb_tag,
    input  ooo_pkg::word_t    cdb_value,
    input  logic              alu_ready,
    output logic              dispatch_stall,
    output logic              dispatch_accept,
    output logic              alu_issue,
    output ooo_pkg::op_t      alu_op,
    output ooo_pkg::word_t    alu_a,
    output ooo_pkg::word_t    alu_b,
    output ooo_pkg::rob_tag_t alu_tag,
    output logic              mul_issue,
    output ooo_pkg::word_t    mul_a,
    output ooo_pkg::word_t    mul_b,
    output ooo_pkg::rob_tag_t mul_tag
);

    localparam int alu_slots = `OOO_ALU_SLOTS;
    localparam int num_slots = `OOO_ALU_SLOTS + `OOO_MUL_SLOTS;
    localparam int slot_bits = $clog2(num_slots);

    ooo_pkg::rs_state_t state [num_slots];
    logic               rdy1  [num_slots];
    logic               rdy2  [num_slots];
    ooo_pkg::op_t       slot_op   [num_slots];
    ooo_pkg::rob_tag_t  slot_dest [num_slots];
    ooo_pkg::rob_tag_t  tag1  [num_slots];
    ooo_pkg::rob_tag_t  tag2  [num_slots];
    ooo_pkg::word_t     val1  [num_slots];
    ooo_pkg::word_t     val2  [num_slots];

    ooo_pkg::fu_class_t   slot_class [num_slots];
    ooo_pkg::fu_class_t   dispatch_class;
    logic                 free_found;
    logic [slot_bits-1:0] free_slot;
    logic [slot_bits-1:0] alu_slot;
    logic [slot_bits-1:0] mul_slot;
    logic                 src1_ready;
    logic                 src2_ready;
    ooo_pkg::word_t       src1_value;
    ooo_pkg::word_t       src2_value;
    logic                 wake1 [num_slots];
    logic                 wake2 [num_slots];

    // Low slots serve the ALU, the rest the multiplier
    always_comb begin
        dispatch_class = (dispatch_op == ooo_pkg::op_mul) ? ooo_pkg::fu_mul : ooo_pkg::fu_alu;
        free_found = 1'b0;
        free_slot  = '0;
        for (int i = 0; i < num_slots; i++) begin
            slot_class[i] = (i < alu_slots) ? ooo_pkg::fu_alu : ooo_pkg::fu_mul;
            if (!free_found && state[i] == ooo_pkg::slot_free &&
                slot_class[i] == dispatch_class) begin
                free_found = 1'b1;
                free_slot  = slot_bits'(i);
            end
        end
    end

    assign dispatch_stall  = rob_full || !free_found;
    assign dispatch_accept = dispatch_valid && !dispatch_stall;

    // Operands come from the register file, then a finished ROB entry, then the live CDB
    always_comb begin
        if (dispatch_op == ooo_pkg::op_li) begin
            src1_ready = 1'b1;
            src1_value = dispatch_imm;
            src2_ready = 1'b1;
            src2_value = '0;
        end else begin
            src1_ready = !rs1_busy || lookup1_done || (cdb_valid && cdb_tag == rs1_tag);
            src1_value = !rs1_busy ? rs1_value : (lookup1_done ? lookup1_value : cdb_value);
            src2_ready = !rs2_busy || lookup2_done || (cdb_valid && cdb_tag == rs2_tag);
            src2_value = !rs2_busy ? rs2_value : (lookup2_done ? lookup2_value : cdb_value);
        end
    end

    always_comb begin
        for (int i = 0; i < num_slots; i++) begin
            wake1[i] = state[i] == ooo_pkg::slot_waiting && !rdy1[i] &&
                       cdb_valid && cdb_tag == tag1[i];
            wake2[i] = state[i] == ooo_pkg::slot_waiting && !rdy2[i] &&
                       cdb_valid && cdb_tag == tag2[i];
        end
    end

    // Lowest ready entry of each class wins
    always_comb begin
        alu_issue = 1'b0;
        alu_slot  = '0;
        mul_issue = 1'b0;
        mul_slot  = '0;
        for (int i = 0; i < num_slots; i++) begin
            if (state[i] == ooo_pkg::slot_ready) begin
                if (slot_class[i] == ooo_pkg::fu_alu) begin
                    if (!alu_issue && alu_ready) begin
                        alu_issue = 1'b1;
                        alu_slot  = slot_bits'(i);
                    end
                end else if (!mul_issue) begin
                    mul_issue = 1'b1;
                    mul_slot  = slot_bits'(i);
                end
            end
        end
    end

    assign alu_op  = slot_op[alu_slot];
    assign alu_a   = val1[alu_slot];
    assign alu_b   = val2[alu_slot];
    assign alu_tag = slot_dest[alu_slot];
    assign mul_a   = val1[mul_slot];
    assign mul_b   = val2[mul_slot];
    assign mul_tag = slot_dest[mul_slot];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_slots; i++) begin
                state[i] <= ooo_pkg::slot_free;
                rdy1[i]  <= 1'b0;
                rdy2[i]  <= 1'b0;
            end
        end else begin
            for (int i = 0; i < num_slots; i++) begin
                if (wake1[i]) rdy1[i] <= 1'b1;
                if (wake2[i]) rdy2[i] <= 1'b1;
                if (state[i] == ooo_pkg::slot_waiting &&
                    (rdy1[i] || wake1[i]) && (rdy2[i] || wake2[i])) begin
                    state[i] <= ooo_pkg::slot_ready;
                end
            end
            if (alu_issue) state[alu_slot] <= ooo_pkg::slot_free;
            if (mul_issue) state[mul_slot] <= ooo_pkg::slot_free;
            if (dispatch_accept) begin
                state[free_slot] <= (src1_ready && src2_ready) ? ooo_pkg::slot_ready
                                                               : ooo_pkg::slot_waiting;
                rdy1[free_slot]  <= src1_ready;
                rdy2[free_slot]  <= src2_ready;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < num_slots; i++) begin
            if (wake1[i]) val1[i] <= cdb_value;   // Capture broadcast result
            if (wake2[i]) val2[i] <= cdb_value;
        end
        if (dispatch_accept) begin
            slot_op[free_slot]   <= dispatch_op;
            slot_dest[free_slot] <= alloc_tag;
            tag1[free_slot]      <= rs1_tag;
            tag2[free_slot]      <= rs2_tag;
            val1[free_slot]      <= src1_value;
            val2[free_slot]      <= src2_value;
        end
    end

endmodule

/* files.f */
+incdir+include
design/ooo_pkg.sv
design/rename_register_file.sv
design/reorder_buffer.sv
design/reservation_station.sv
design/exec_units.sv
design/ooo_core.sv
verification/ooo_core_sva.sv
verification/ooo_core_tb.sv

/* include/ooo_config.svh */
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// Datapath width in bits
`define OOO_XLEN 32

// Architectural registers with register 0 reading zero
`define OOO_NUM_REGS 32

// In-flight window kept a power of two so the tags wrap naturally
`define OOO_ROB_DEPTH 8

// Reservation station entries per functional unit class
`define OOO_ALU_SLOTS 3
`define OOO_MUL_SLOTS 2

`endif

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ooo_core_tb -f files.f -o ooo_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/ooo_core_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q -F '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

/* verification/ooo_core_sva.sv */
`timescale 1ns/10ps
`include "ooo_config.svh"

module ooo_core_sva (
    input logic              clock,
    input logic              reset,
    input logic              dispatch_stall,
    input ooo_pkg::rob_tag_t alloc_tag,
    input logic              commit_valid,
    input ooo_pkg::rob_tag_t commit_tag
);

    ooo_pkg::rob_tag_t last_tag;

    // Starts one below zero so the first commit after reset carries tag 0
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            last_tag <= ooo_pkg::rob_tag_t'(`OOO_ROB_DEPTH - 1);
        end else if (commit_valid) begin
            last_tag <= commit_tag;
        end
    end

    // A stalled dispatch must not take a ROB entry
    accept_while_stalled: assert property (@(posedge clock) disable iff (reset)
        dispatch_stall |=> alloc_tag == $past(alloc_tag))
        else $error("ROB allocated an entry while dispatch_stall was high");

    commit_in_reset: assert property (@(posedge clock) reset |-> !commit_valid)
        else $error("commit_valid high during reset");

    // Retirement is strictly in ROB order
    commit_tag_order: assert property (@(posedge clock) disable iff (reset)
        commit_valid |-> int'(commit_tag) == (int'(last_tag) + 1) % `OOO_ROB_DEPTH)
        else $error("commit_tag %0d does not follow %0d", commit_tag, last_tag);

endmodule

bind ooo_core ooo_core_sva i_sva (
    .clock          (clock),
    .reset          (reset),
    .dispatch_stall (dispatch_stall),
    .alloc_tag      (alloc_tag),
    .commit_valid   (commit_valid),
    .commit_tag     (commit_tag)
);

/* verification/ooo_core_tb.sv */
`timescale 1ns/10ps
`include "ooo_config.svh"

module ooo_core_tb;

    localparam int planned_dispatches = 100;   // Sum over all tests below

    logic                clock;
    logic                reset;
    logic                dispatch_valid;
    ooo_pkg::op_t        dispatch_op;
    ooo_pkg::reg_index_t dispatch_rd;
    ooo_pkg::reg_index_t dispatch_rs1;
    ooo_pkg::reg_index_t dispatch_rs2;
    ooo_pkg::word_t      dispatch_imm;
    logic                dispatch_stall;
    logic                commit_valid;
    ooo_pkg::reg_index_t commit_rd;
    ooo_pkg::rob_tag_t   commit_tag;
    ooo_pkg::word_t      commit_value;

    // Reference model of architectural state in program order
    ooo_pkg::word_t      model_reg [`OOO_NUM_REGS];
    ooo_pkg::reg_index_t expect_rd [$];
    ooo_pkg::word_t      expect_value [$];

    string       test_name;
    int          checks;
    int          errors;
    int          commits;
    int          dispatched;
    int          stall_cycles;
    logic [31:0] rand_state;

    ooo_core i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state >> 16;   // Upper bits since the low ones cycle quickly
    endfunction

    function automatic ooo_pkg::word_t model_result(input ooo_pkg::op_t op,
            input ooo_pkg::word_t a, input ooo_pkg::word_t b, input ooo_pkg::word_t imm);
        case (op)
            ooo_pkg::op_add: return a + b;
            ooo_pkg::op_sub: return a - b;
            ooo_pkg::op_and: return a & b;
            ooo_pkg::op_or:  return a | b;
            ooo_pkg::op_xor: return a ^ b;
            ooo_pkg::op_li:  return imm;
            ooo_pkg::op_mul: return a * b;   // Low word only
            default:         return '0;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
            input logic [31:0] actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic watch_commits();
        forever begin
            @(negedge clock);
            if (!reset && commit_valid) begin
                commits++;
                checks++;
                assert (expect_rd.size() != 0) else begin
                    errors++;
                    $display("Commit of register %0d arrived with no instruction pending",
                             commit_rd);
                end
                if (expect_rd.size() != 0) begin
                    check_value("commit rd", 32'(expect_rd.pop_front()), 32'(commit_rd));
                    check_value("commit value", expect_value.pop_front(), commit_value);
                end
            end
        end
    endtask

    // Called at 1 ns after a rising edge, returns at the same point
    task automatic dispatch(input ooo_pkg::op_t op, input ooo_pkg::reg_index_t rd,
            input ooo_pkg::reg_index_t rs1, input ooo_pkg::reg_index_t rs2,
            input ooo_pkg::word_t imm);
        ooo_pkg::word_t result;
        result         = model_result(op, model_reg[rs1], model_reg[rs2], imm);
        dispatch_valid = 1'b1;
        dispatch_op    = op;
        dispatch_rd    = rd;
        dispatch_rs1   = rs1;
        dispatch_rs2   = rs2;
        dispatch_imm   = imm;
        @(negedge clock);
        while (dispatch_stall) begin   // Inputs held while stalled
            stall_cycles++;
            @(negedge clock);
        end
        @(posedge clock);
        #1;
        dispatch_valid = 1'b0;
        if (rd != '0) model_reg[rd] = result;
        expect_rd.push_back(rd);
        expect_value.push_back(result);
        dispatched++;
    endtask

    task automatic drain();
        while (expect_rd.size() != 0) @(negedge clock);
        @(posedge clock);
        #1;
    endtask

    task automatic reset_state();
        test_name = "reset_state";
        @(negedge clock);
        check_value("dispatch_stall", 32'd0, 32'(dispatch_stall));
        check_value("commit_valid", 32'd0, 32'(commit_valid));
        @(posedge clock);
        #1;
        dispatch(ooo_pkg::op_add, 5'd1, 5'd2, 5'd3, 32'd0);   // All sources read zero
        dispatch(ooo_pkg::op_or, 5'd4, 5'd31, 5'd30, 32'd0);
        dispatch(ooo_pkg::op_xor, 5'd5, 5'd6, 5'd7, 32'd0);
        dispatch(ooo_pkg::op_sub, 5'd8, 5'd9, 5'd10, 32'd0);
        drain();
    endtask

    task automatic alu_ops();
        test_name = "alu_ops";
        dispatch(ooo_pkg::op_li, 5'd11, 5'd0, 5'd0, 32'h1234_5678);
        dispatch(ooo_pkg::op_li, 5'd12, 5'd0, 5'd0, 32'h0f0f_00ff);
        dispatch(ooo_pkg::op_li, 5'd13, 5'd0, 5'd0, 32'd100);
        dispatch(ooo_pkg::op_li, 5'd14, 5'd0, 5'd0, 32'hffff_0000);
        dispatch(ooo_pkg::op_li, 5'd15, 5'd0, 5'd0, 32'd3);
        dispatch(ooo_pkg::op_add, 5'd16, 5'd13, 5'd15, 32'd0);
        dispatch(ooo_pkg::op_sub, 5'd17, 5'd15, 5'd13, 32'd0);   // Wraps negative
        dispatch(ooo_pkg::op_and, 5'd18, 5'd11, 5'd12, 32'd0);
        dispatch(ooo_pkg::op_or, 5'd19, 5'd12, 5'd14, 32'd0);
        dispatch(ooo_pkg::op_xor, 5'd20, 5'd11, 5'd14, 32'd0);
        drain();
    endtask

    task automatic dependency_chain();
        test_name = "dependency_chain";
        dispatch(ooo_pkg::op_li, 5'd1, 5'd0, 5'd0, 32'd7);
        dispatch(ooo_pkg::op_li, 5'd2, 5'd0, 5'd0, 32'd9);
        dispatch(ooo_pkg::op_mul, 5'd3, 5'd1, 5'd2, 32'd0);
        dispatch(ooo_pkg::op_add, 5'd4, 5'd3, 5'd1, 32'd0);   // Woken by the CDB
        dispatch(ooo_pkg::op_mul, 5'd5, 5'd4, 5'd3, 32'd0);
        dispatch(ooo_pkg::op_add, 5'd6, 5'd5, 5'd4, 32'd0);
        dispatch(ooo_pkg::op_sub, 5'd7, 5'd6, 5'd2, 32'd0);
        drain();
        dispatch(ooo_pkg::op_add, 5'd8, 5'd3, 5'd5, 32'd0);
        drain();
    endtask

    task automatic mul_backpressure();
        int stalls_before;
        int commits_before;
        int dispatched_before;
        test_name         = "mul_backpressure";
        stalls_before     = stall_cycles;
        commits_before    = commits;
        dispatched_before = dispatched;
        dispatch(ooo_pkg::op_li, 5'd21, 5'd0, 5'd0, 32'd3);
        dispatch(ooo_pkg::op_li, 5'd22, 5'd0, 5'd0, 32'h0001_0001);
        // Each multiply waits on the one before, filling the two slots
        for (int i = 0; i < 8; i++) begin
            dispatch(ooo_pkg::op_mul, ooo_pkg::reg_index_t'(23 + i),
                     ooo_pkg::reg_index_t'(22 + i), 5'd21, 32'd0);
        end
        drain();
        check_value("stall seen", 32'd1, 32'(stall_cycles != stalls_before));
        check_value("commit count", 32'(dispatched - dispatched_before),
                    32'(commits - commits_before));
    endtask

    task automatic random_program();
        ooo_pkg::op_t        op;
        ooo_pkg::reg_index_t rd;
        ooo_pkg::reg_index_t rs1;
        ooo_pkg::reg_index_t rs2;
        ooo_pkg::word_t      imm;
        test_name = "random_program";
        for (int i = 0; i < 60; i++) begin
            op  = ooo_pkg::op_t'(3'(next_random() % 7));
            rd  = ooo_pkg::reg_index_t'(1 + next_random() % 7);   // Few registers give many hazards
            rs1 = ooo_pkg::reg_index_t'(next_random() % 8);
            rs2 = ooo_pkg::reg_index_t'(next_random() % 8);
            imm = next_random() * 32'd40503;
            dispatch(op, rd, rs1, rs2, imm);
        end
        drain();
        // The second writer of r9 finishes long after the first commits
        dispatch(ooo_pkg::op_li, 5'd9, 5'd0, 5'd0, 32'h0bad_0001);
        dispatch(ooo_pkg::op_mul, 5'd12, 5'd9, 5'd9, 32'd0);
        dispatch(ooo_pkg::op_mul, 5'd9, 5'd12, 5'd12, 32'd0);
        for (int i = 0; i < 4; i++) begin
            dispatch(ooo_pkg::op_add, ooo_pkg::reg_index_t'(13 + i), 5'd9, 5'd0, 32'd0);
        end
        drain();
        dispatch(ooo_pkg::op_add, 5'd11, 5'd9, 5'd0, 32'd0);
        drain();
    endtask

    initial begin
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op    = ooo_pkg::op_add;
        dispatch_rd    = '0;
        dispatch_rs1   = '0;
        dispatch_rs2   = '0;
        dispatch_imm   = '0;
        rand_state     = 32'h0d81d38f;
        checks         = 0;
        errors         = 0;
        commits        = 0;
        dispatched     = 0;
        stall_cycles   = 0;
        test_name      = "none";
        for (int i = 0; i < `OOO_NUM_REGS; i++) model_reg[i] = '0;
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
        fork
            watch_commits();
        join_none
        reset_state();
        alu_ops();
        dependency_chain();
        mul_backpressure();
        random_program();
        $display("Checks: %0d, errors: %0d, dispatches: %0d, commits: %0d",
                 checks, errors, dispatched, commits);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (20 * planned_dispatches + 200) @(posedge clock);
        $display("Timeout: tests did not finish in %0d cycles",
                 20 * planned_dispatches + 200);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
